/* build.f */
+incdir+include
rtl/dcache_pkg.sv
rtl/dcache_way_if.sv
rtl/dcache_way.sv
rtl/dcache_select.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
dv/tb_dcache.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_dcache -f build.f -o tb_dcache \
	> build.log 2>&1 \
	&& ./obj_dir/tb_dcache > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "FAIL: build or run error"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"

/* dv/tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module tb_dcache;
	import dcache_pkg::*;

	// about 400 requests over all tests, each allowed 200 cycles
	localparam int MAX_REQS       = 400;
	localparam int TIMEOUT_CYCLES = 200 * MAX_REQS + 1000;

	logic      i_clk = 1'b0;
	logic      i_rst;
	logic      i_req_valid;
	word_t     i_req_addr;
	logic [3:0] i_req_wen;
	word_t     i_req_wdata;
	logic      o_stall;
	logic      o_resp_valid;
	word_t     o_rdata;
	logic      o_mem_rd_req;
	word_t     o_mem_rd_addr;
	logic      i_mem_rd_valid;
	word_t     i_mem_rd_data;
	logic      o_wb_valid;
	word_t     o_wb_addr;
	line_t     o_wb_data;
	logic      i_wb_credit;

	word_t     golden_mem [word_t];
	word_t     backing_mem [word_t];
	word_t     exp_q [$];
	bit        touched [word_t];
	int        word_errs = 0;
	int        line_errs = 0;
	int        flag_errs = 0;
	int        other_errs = 0;
	int        cycle_cnt = 0;
	int        rd_cnt = 0;
	int        wb_cnt = 0;
	int        credit_ret_cnt = 0;
	bit        hold_credits = 1'b0;
	word_t     last_wb_addr = '0;

	dcache_top i_dut (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_req_valid    (i_req_valid),
		.i_req_addr     (i_req_addr),
		.i_req_wen      (i_req_wen),
		.i_req_wdata    (i_req_wdata),
		.o_stall        (o_stall),
		.o_resp_valid   (o_resp_valid),
		.o_rdata        (o_rdata),
		.o_mem_rd_req   (o_mem_rd_req),
		.o_mem_rd_addr  (o_mem_rd_addr),
		.i_mem_rd_valid (i_mem_rd_valid),
		.i_mem_rd_data  (i_mem_rd_data),
		.o_wb_valid     (o_wb_valid),
		.o_wb_addr      (o_wb_addr),
		.o_wb_data      (o_wb_data),
		.i_wb_credit    (i_wb_credit)
	);

	always #4 i_clk = ~i_clk;

	// contents of memory never written, every address bit takes part
	function automatic word_t init_word(input word_t a);
		return {a[18:0], a[31:19]} ^ (a * 32'h0001_0193) ^ 32'h6d2b_79f5;
	endfunction

	// reference model of what a load must return
	function automatic word_t golden_load(input word_t addr);
		word_t wa;
		wa = {addr[31:2], 2'b00};
		if (golden_mem.exists(wa)) begin
			return golden_mem[wa];
		end
		return init_word(wa);
	endfunction

	function automatic void golden_store(input word_t addr, input logic [3:0] be,
			input word_t data);
		word_t w;
		w = golden_load(addr);
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				w[8*b +: 8] = data[8*b +: 8];
			end
		end
		golden_mem[{addr[31:2], 2'b00}] = w;
	endfunction

	function automatic word_t mem_word(input word_t a);
		if (backing_mem.exists(a)) begin
			return backing_mem[a];
		end
		return init_word(a);
	endfunction

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			flag_errs++;
			$display("[ERROR] %s got 0x%0h exp 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			word_errs++;
			$display("[ERROR] %s got 0x%08h exp 0x%08h", name, got, exp);
		end
	endtask

	// an evicted line must hold what the CPU has stored so far
	task automatic check_line(input word_t addr, input line_t got);
		word_t exp;
		for (int w = 0; w < `DC_WORDS_PER_LINE; w++) begin
			exp = golden_load(addr + word_t'(4 * w));
			if (got[w] !== exp) begin
				line_errs++;
				$display("[ERROR] o_wb_data[%0d] at 0x%08h got 0x%08h exp 0x%08h",
					w, addr, got[w], exp);
			end
		end
	endtask

	// called at a falling edge, returns at the falling edge after acceptance
	task automatic issue_req(input word_t addr, input logic [3:0] be, input word_t data);
		i_req_valid = 1'b1;
		i_req_addr  = addr;
		i_req_wen   = be;
		i_req_wdata = data;
		while (o_stall === 1'b1) begin
			@(negedge i_clk);
		end
		if (be == 4'h0) begin
			exp_q.push_back(golden_load(addr));
		end else begin
			golden_store(addr, be, data);
		end
		@(negedge i_clk);
		i_req_valid = 1'b0;
	endtask

	task automatic load_from(input word_t addr);
		issue_req(addr, 4'h0, '0);
	endtask

	task automatic store_to(input word_t addr, input logic [3:0] be, input word_t data);
		issue_req(addr, be, data);
	endtask

	task automatic drain_pipeline();
		repeat (2) @(negedge i_clk);
		while (exp_q.size() != 0 || o_stall === 1'b1) begin
			@(negedge i_clk);
		end
	endtask

	always @(negedge i_clk) begin : resp_compare
		word_t exp;
		if (o_resp_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				other_errs++;
				$display("error: load response with no load outstanding");
			end else begin
				exp = exp_q.pop_front();
				check_word("o_rdata", o_rdata, exp);
			end
		end
	end

	// refill after 1 to 6 cycles, random gaps between words
	initial begin : mem_read_model
		word_t base;
		i_mem_rd_valid = 1'b0;
		i_mem_rd_data  = '0;
		forever begin
			@(negedge i_clk);
			i_mem_rd_valid = 1'b0;
			if (o_mem_rd_req === 1'b1) begin
				base = o_mem_rd_addr;
				rd_cnt++;
				if (base % (4 * `DC_WORDS_PER_LINE) != 0) begin
					other_errs++;
					$display("error: refill address 0x%08h is not line aligned", base);
				end
				repeat ($urandom_range(6, 1)) @(negedge i_clk);
				for (int w = 0; w < `DC_WORDS_PER_LINE; w++) begin
					repeat ($urandom_range(2, 0)) @(negedge i_clk);
					i_mem_rd_valid = 1'b1;
					i_mem_rd_data  = mem_word(base + word_t'(4 * w));
					@(negedge i_clk);
					i_mem_rd_valid = 1'b0;
				end
			end
		end
	end

	// takes evicted lines and hands credits back after a random delay
	initial begin : wb_sink
		int due_q [$];
		i_wb_credit = 1'b0;
		forever begin
			@(negedge i_clk);
			i_wb_credit = 1'b0;
			if (o_wb_valid === 1'b1) begin
				wb_cnt++;
				last_wb_addr = o_wb_addr;
				if (wb_cnt > `DC_WB_CREDITS + credit_ret_cnt) begin
					other_errs++;
					$display("error: write-back sent while no credit was left");
				end
				check_line(o_wb_addr, o_wb_data);
				for (int w = 0; w < `DC_WORDS_PER_LINE; w++) begin
					backing_mem[o_wb_addr + word_t'(4 * w)] = o_wb_data[w];
				end
				due_q.push_back(cycle_cnt + int'($urandom_range(8, 1)));
			end
			if (!hold_credits && due_q.size() != 0 && cycle_cnt >= due_q[0]) begin
				void'(due_q.pop_front());
				i_wb_credit = 1'b1;
				credit_ret_cnt++;
			end
		end
	end

	initial begin : watchdog
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge i_clk);
			cycle_cnt++;
		end
		$display("error: timeout, test did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("Checks failed");
		$finish;
	end

	initial begin : main
		word_t a;
		word_t b;
		word_t c;
		int    start;
		int    total;
		logic [3:0] be;
		void'($urandom(32'h96b69456));
		i_rst       = 1'b1;
		i_req_valid = 1'b0;
		i_req_addr  = '0;
		i_req_wen   = '0;
		i_req_wdata = '0;
		repeat (8) @(negedge i_clk);
		i_rst = 1'b0;

		// invalidation walk, one set per cycle
		for (int s = 0; s < `DC_SETS; s++) begin
			check_flag("o_stall", o_stall, 1'b1);
			check_flag("o_resp_valid", o_resp_valid, 1'b0);
			check_flag("o_mem_rd_req", o_mem_rd_req, 1'b0);
			check_flag("o_wb_valid", o_wb_valid, 1'b0);
			@(negedge i_clk);
		end
		check_flag("o_stall", o_stall, 1'b0);

		// load miss, then hits streaming in the same line
		a = 32'h0000_1020;
		start = rd_cnt;
		load_from(a);
		for (int w = 1; w <= `DC_WORDS_PER_LINE; w++) begin
			load_from(a + word_t'(4 * (w % `DC_WORDS_PER_LINE)));
		end
		drain_pipeline();
		if (rd_cnt - start != 1) begin
			other_errs++;
			$display("error: expected one refill for one line, saw %0d", rd_cnt - start);
		end

		// partial stores on a hit and on a miss
		a = 32'h0000_2030;
		b = 32'h0000_3030;
		load_from(a);
		store_to(a + 4, 4'b0101, 32'h1122_3344);
		load_from(a + 4);
		store_to(a + 8, 4'b1000, 32'hdead_beef);
		load_from(a + 8);
		store_to(b + 12, 4'b0110, 32'h5566_7788);
		load_from(b + 12);
		load_from(b);
		drain_pipeline();

		// A, B, A, C in one set evicts B, which is dirty here
		a = 32'h0001_0050;
		b = 32'h0002_0050;
		c = 32'h0003_0050;
		load_from(a);
		store_to(b + 4, 4'b0011, 32'h0bad_cafe);
		load_from(a);
		drain_pipeline();
		start = wb_cnt;
		load_from(c);
		drain_pipeline();
		if (wb_cnt - start != 1) begin
			other_errs++;
			$display("error: expected one write-back of the dirty line, saw %0d",
				wb_cnt - start);
		end
		check_word("o_wb_addr", last_wb_addr, b);
		load_from(b + 4);
		drain_pipeline();

		// same order with clean lines writes nothing back
		a = 32'h0001_0060;
		b = 32'h0002_0060;
		c = 32'h0003_0060;
		load_from(a);
		load_from(b);
		load_from(a);
		start = wb_cnt;
		load_from(c);
		drain_pipeline();
		if (wb_cnt != start) begin
			other_errs++;
			$display("error: clean victim was written back");
		end

		// credits withheld, evictions stop after the initial ones
		while (wb_cnt != credit_ret_cnt) begin
			@(negedge i_clk);
		end
		hold_credits = 1'b1;
		start = wb_cnt;
		fork
			begin
				for (int k = 0; k < 6; k++) begin
					store_to(32'h0100_0090 + word_t'(k * 256), 4'b1111, $urandom);
				end
			end
			begin
				wait (wb_cnt == start + `DC_WB_CREDITS);
				repeat (40) @(negedge i_clk);
				if (wb_cnt != start + `DC_WB_CREDITS) begin
					other_errs++;
					$display("error: write-back continued without credits");
				end
				check_flag("o_stall", o_stall, 1'b1);
				hold_credits = 1'b0;
			end
		join
		drain_pipeline();
		if (wb_cnt - start != 4) begin
			other_errs++;
			$display("error: expected four write-backs in credit test, saw %0d",
				wb_cnt - start);
		end
		load_from(32'h0100_0090);
		load_from(32'h0100_0190);
		drain_pipeline();

		// random mix over sets 12 to 15, four tags each
		for (int i = 0; i < 300; i++) begin
			a = 32'h0400_0000 + (word_t'($urandom_range(3, 0)) << 8)
				+ (word_t'($urandom_range(15, 12)) << 4)
				+ (word_t'($urandom_range(3, 0)) << 2);
			touched[a] = 1'b1;
			if ($urandom_range(1, 0) == 1) begin
				be = 4'h0;
			end else begin
				be = 4'($urandom_range(15, 1));
			end
			issue_req(a, be, $urandom);
		end
		foreach (touched[key]) begin
			load_from(key);
		end
		drain_pipeline();

		total = word_errs + line_errs + flag_errs + other_errs;
		$display("error counts: data %0d, line %0d, flag %0d, other %0d",
			word_errs, line_errs, flag_errs, other_errs);
		if (total == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_top (
	input  wire                    i_clk,
	input  wire                    i_rst,
	input  wire                    i_req_valid,
	input  wire dcache_pkg::word_t i_req_addr,
	input  wire [3:0]              i_req_wen,
	input  wire dcache_pkg::word_t i_req_wdata,
	output logic                   o_stall,
	output logic                   o_resp_valid,
	output dcache_pkg::word_t      o_rdata,
	output logic                   o_mem_rd_req,
	output dcache_pkg::word_t      o_mem_rd_addr,
	input  wire                    i_mem_rd_valid,
	input  wire dcache_pkg::word_t i_mem_rd_data,
	output logic                   o_wb_valid,
	output dcache_pkg::word_t      o_wb_addr,
	output dcache_pkg::line_t      o_wb_data,
	input  wire                    i_wb_credit
);
	import dcache_pkg::*;

	logic                 hit;
	way_idx_t             hit_way;
	word_t                load_word;
	way_idx_t             victim_way;
	logic                 victim_dirty;
	logic [`DC_TAG_W-1:0] victim_tag;
	line_t                victim_line;
	logic                 touch;
	way_idx_t             touch_way;

	dcache_way_if way_if [`DC_WAYS] ();

	dcache_ctrl u_ctrl (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_req_valid    (i_req_valid),
		.i_req_addr     (i_req_addr),
		.i_req_wen      (i_req_wen),
		.i_req_wdata    (i_req_wdata),
		.o_stall        (o_stall),
		.o_resp_valid   (o_resp_valid),
		.o_rdata        (o_rdata),
		.o_mem_rd_req   (o_mem_rd_req),
		.o_mem_rd_addr  (o_mem_rd_addr),
		.i_mem_rd_valid (i_mem_rd_valid),
		.i_mem_rd_data  (i_mem_rd_data),
		.o_wb_valid     (o_wb_valid),
		.o_wb_addr      (o_wb_addr),
		.o_wb_data      (o_wb_data),
		.i_wb_credit    (i_wb_credit),
		.way_if         (way_if),
		.i_hit          (hit),
		.i_hit_way      (hit_way),
		.i_load_word    (load_word),
		.i_victim_way   (victim_way),
		.i_victim_dirty (victim_dirty),
		.i_victim_tag   (victim_tag),
		.i_victim_line  (victim_line),
		.o_touch        (touch),
		.o_touch_way    (touch_way)
	);

	for (genvar g = 0; g < `DC_WAYS; g++) begin : g_ways
		dcache_way u_way (
			.i_clk  (i_clk),
			.way_if (way_if[g])
		);
	end

	dcache_select u_select (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.way_if         (way_if),
		.i_touch        (touch),
		.i_touch_way    (touch_way),
		.o_hit          (hit),
		.o_hit_way      (hit_way),
		.o_load_word    (load_word),
		.o_victim_way   (victim_way),
		.o_victim_dirty (victim_dirty),
		.o_victim_tag   (victim_tag),
		.o_victim_line  (victim_line)
	);

endmodule

`default_nettype wire

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_ctrl (
	input  wire                       i_clk,
	input  wire                       i_rst,
	input  wire                       i_req_valid,
	input  wire dcache_pkg::word_t    i_req_addr,
	input  wire [3:0]                 i_req_wen,
	input  wire dcache_pkg::word_t    i_req_wdata,
	output logic                      o_stall,
	output logic                      o_resp_valid,
	output dcache_pkg::word_t         o_rdata,
	output logic                      o_mem_rd_req,
	output dcache_pkg::word_t         o_mem_rd_addr,
	input  wire                       i_mem_rd_valid,
	input  wire dcache_pkg::word_t    i_mem_rd_data,
	output logic                      o_wb_valid,
	output dcache_pkg::word_t         o_wb_addr,
	output dcache_pkg::line_t         o_wb_data,
	input  wire                       i_wb_credit,
	dcache_way_if.ctrl                way_if [`DC_WAYS],
	input  wire                       i_hit,
	input  wire dcache_pkg::way_idx_t i_hit_way,
	input  wire dcache_pkg::word_t    i_load_word,
	input  wire dcache_pkg::way_idx_t i_victim_way,
	input  wire                       i_victim_dirty,
	input  wire [`DC_TAG_W-1:0]       i_victim_tag,
	input  wire dcache_pkg::line_t    i_victim_line,
	output logic                      o_touch,
	output dcache_pkg::way_idx_t      o_touch_way
);
	import dcache_pkg::*;

	localparam int CREDIT_W = $clog2(`DC_WB_CREDITS + 1);

	typedef enum logic [2:0] {
		ST_INV,
		ST_IDLE,
		ST_WB,
		ST_RWAIT,
		ST_FILL,
		ST_REPLAY
	} state_t;

	state_t                        state_q;
	logic [`DC_INDEX_W-1:0]        inv_cnt_q;
	logic                          req_valid_q;
	addr_u                         req_q;
	logic [3:0]                    req_wen_q;
	word_t                         req_wdata_q;
	way_idx_t                      victim_way_q;
	logic                          rd_req_q;
	logic [`DC_OFFSET_W-1:0]       word_cnt_q;
	line_t                         fill_q;
	logic [CREDIT_W-1:0]           credit_q;

	logic                          lookup;
	logic                          miss;
	logic                          store_hit;
	logic                          wb_send;
	word_t                         merged_word;
	logic [`DC_WORDS_PER_LINE-1:0] store_mask;
	addr_u                         rd_addr;
	addr_u                         wb_addr;

	function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
			input logic [3:0] be);
		word_t res;
		for (int b = 0; b < 4; b++) begin
			res[8*b +: 8] = be[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
		end
		return res;
	endfunction

	// a replay is an ordinary lookup that is known to hit
	assign lookup      = req_valid_q && (state_q == ST_IDLE || state_q == ST_REPLAY);
	assign miss        = lookup && !i_hit;
	assign store_hit   = lookup && i_hit && (|req_wen_q);
	assign wb_send     = (state_q == ST_WB) && (credit_q != '0);
	assign merged_word = merge_bytes(i_load_word, req_wdata_q, req_wen_q);

	always_comb begin
		store_mask = '0;
		store_mask[req_q.f.word_off] = 1'b1;
	end

	// cpu side
	assign o_stall      = !(state_q == ST_IDLE || state_q == ST_REPLAY) || miss;
	assign o_resp_valid = lookup && i_hit && !(|req_wen_q);
	assign o_rdata      = i_load_word;
	assign o_touch      = lookup && i_hit;
	assign o_touch_way  = i_hit_way;

	// line-aligned addresses for both memory channels
	always_comb begin
		rd_addr = '0;
		rd_addr.f.tag = req_q.f.tag;
		rd_addr.f.index = req_q.f.index;
		wb_addr = rd_addr;
		wb_addr.f.tag = i_victim_tag;
	end

	assign o_mem_rd_req  = rd_req_q;
	assign o_mem_rd_addr = rd_addr.raw;
	assign o_wb_valid    = wb_send;
	assign o_wb_addr     = wb_addr.raw;
	assign o_wb_data     = i_victim_line;

	// way writes: invalidate walk, whole-line fill, or one merged store word
	for (genvar g = 0; g < `DC_WAYS; g++) begin : g_way_drive
		assign way_if[g].lk_index  = req_q.f.index;
		assign way_if[g].lk_tag    = req_q.f.tag;
		assign way_if[g].lk_offset = req_q.f.word_off;
		assign way_if[g].wr_index  = (state_q == ST_INV) ? inv_cnt_q : req_q.f.index;
		assign way_if[g].wr_line   = (state_q == ST_FILL) ? fill_q
			: {`DC_WORDS_PER_LINE{merged_word}};
		assign way_if[g].wr_tag    = req_q.f.tag;
		assign way_if[g].wr_valid  = (state_q != ST_INV);
		assign way_if[g].wr_dirty  = store_hit;

		always_comb begin
			way_if[g].wr_en = '0;
			if (state_q == ST_INV) begin
				way_if[g].wr_en = '1;
			end else if (state_q == ST_FILL && victim_way_q == way_idx_t'(g)) begin
				way_if[g].wr_en = '1;
			end else if (store_hit && i_hit_way == way_idx_t'(g)) begin
				way_if[g].wr_en = store_mask;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state_q     <= ST_INV;
			inv_cnt_q   <= '0;
			req_valid_q <= 1'b0;
			rd_req_q    <= 1'b0;
			word_cnt_q  <= '0;
			credit_q    <= CREDIT_W'(`DC_WB_CREDITS);
		end else begin
			rd_req_q <= 1'b0;
			credit_q <= credit_q + CREDIT_W'(i_wb_credit) - CREDIT_W'(wb_send);
			if (!o_stall) begin
				req_valid_q <= i_req_valid;
			end
			case (state_q)
				ST_INV: begin
					inv_cnt_q <= inv_cnt_q + 1'b1;
					if (inv_cnt_q == `DC_SETS - 1) begin
						state_q <= ST_IDLE;
					end
				end
				ST_IDLE, ST_REPLAY: begin
					state_q <= ST_IDLE;
					if (miss) begin
						if (i_victim_dirty) begin
							state_q <= ST_WB;
						end else begin
							state_q  <= ST_RWAIT;
							rd_req_q <= 1'b1;
						end
					end
				end
				// held here until a credit is available
				ST_WB: begin
					if (wb_send) begin
						state_q  <= ST_RWAIT;
						rd_req_q <= 1'b1;
					end
				end
				ST_RWAIT: begin
					if (i_mem_rd_valid) begin
						word_cnt_q <= word_cnt_q + 1'b1;
						if (word_cnt_q == `DC_WORDS_PER_LINE - 1) begin
							state_q <= ST_FILL;
						end
					end
				end
				ST_FILL: begin
					state_q <= ST_REPLAY;
				end
				default: begin
					state_q <= ST_INV;
				end
			endcase
		end
	end

	// request payload, victim way and refill buffer
	always_ff @(posedge i_clk) begin
		if (!o_stall) begin
			req_q.raw   <= i_req_addr;
			req_wen_q   <= i_req_wen;
			req_wdata_q <= i_req_wdata;
		end
		if (miss) begin
			victim_way_q <= i_victim_way;
		end
		if (state_q == ST_RWAIT && i_mem_rd_valid) begin
			fill_q[word_cnt_q] <= i_mem_rd_data;
		end
	end

endmodule

`default_nettype wire

/* rtl/dcache_select.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_select (
	input  wire                       i_clk,
	input  wire                       i_rst,
	dcache_way_if.sel                 way_if [`DC_WAYS],
	input  wire                       i_touch,
	input  wire dcache_pkg::way_idx_t i_touch_way,
	output logic                      o_hit,
	output dcache_pkg::way_idx_t      o_hit_way,
	output dcache_pkg::word_t         o_load_word,
	output dcache_pkg::way_idx_t      o_victim_way,
	output logic                      o_victim_dirty,
	output logic [`DC_TAG_W-1:0]      o_victim_tag,
	output dcache_pkg::line_t         o_victim_line
);
	import dcache_pkg::*;

	logic [`DC_WAYS-1:0]     hits;
	logic [`DC_WAYS-1:0]     valids;
	logic [`DC_WAYS-1:0]     dirtys;
	logic [`DC_TAG_W-1:0]    tags [`DC_WAYS];
	line_t                   lines [`DC_WAYS];
	logic [`DC_SETS-1:0]     lru_q;
	logic [`DC_INDEX_W-1:0]  set_idx;
	logic [`DC_OFFSET_W-1:0] word_idx;

	// gather the per-way outputs into arrays
	for (genvar g = 0; g < `DC_WAYS; g++) begin : g_gather
		assign hits[g]   = way_if[g].hit;
		assign valids[g] = way_if[g].valid;
		assign dirtys[g] = way_if[g].dirty;
		assign tags[g]   = way_if[g].tag;
		assign lines[g]  = way_if[g].line;
	end

	// all ways see the same lookup fields
	assign set_idx  = way_if[0].lk_index;
	assign word_idx = way_if[0].lk_offset;

	// with two ways the hit way is just way 1's hit
	assign o_hit       = |hits;
	assign o_hit_way   = way_idx_t'(hits[1]);
	assign o_load_word = lines[o_hit_way][word_idx];

	// lru bit names the way to replace next
	assign o_victim_way   = way_idx_t'(lru_q[set_idx]);
	assign o_victim_dirty = valids[o_victim_way] && dirtys[o_victim_way];
	assign o_victim_tag   = tags[o_victim_way];
	assign o_victim_line  = lines[o_victim_way];

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			lru_q <= '0;
		end else if (i_touch) begin
			// point away from the way just used
			lru_q[set_idx] <= ~i_touch_way;
		end
	end

endmodule

`default_nettype wire

/* rtl/dcache_way.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

module dcache_way (
	input  wire       i_clk,
	dcache_way_if.way way_if
);
	import dcache_pkg::*;

	logic [`DC_SETS-1:0]  valid_q;
	logic [`DC_SETS-1:0]  dirty_q;
	logic [`DC_TAG_W-1:0] tag_mem [`DC_SETS];
	line_t                data_mem [`DC_SETS];

	// state bits follow any write, data only where the word enable is set
	always_ff @(posedge i_clk) begin
		if (|way_if.wr_en) begin
			valid_q[way_if.wr_index] <= way_if.wr_valid;
			dirty_q[way_if.wr_index] <= way_if.wr_dirty;
			tag_mem[way_if.wr_index] <= way_if.wr_tag;
		end
		for (int w = 0; w < `DC_WORDS_PER_LINE; w++) begin
			if (way_if.wr_en[w]) begin
				data_mem[way_if.wr_index][w] <= way_if.wr_line[w];
			end
		end
	end

	// asynchronous read at the lookup index
	assign way_if.valid = valid_q[way_if.lk_index];
	assign way_if.dirty = dirty_q[way_if.lk_index];
	assign way_if.tag   = tag_mem[way_if.lk_index];
	assign way_if.line  = data_mem[way_if.lk_index];

	// tag compare
	assign way_if.hit = way_if.valid && (way_if.tag == way_if.lk_tag);

endmodule

`default_nettype wire

/* rtl/dcache_way_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "dcache_settings.svh"

interface dcache_way_if;
	import dcache_pkg::*;

	// lookup side, from the registered request
	logic [`DC_INDEX_W-1:0]       lk_index;
	logic [`DC_TAG_W-1:0]         lk_tag;
	logic [`DC_OFFSET_W-1:0]      lk_offset;

	// write side, one enable bit per word of the line
	logic [`DC_WORDS_PER_LINE-1:0] wr_en;
	logic [`DC_INDEX_W-1:0]       wr_index;
	line_t                        wr_line;
	logic [`DC_TAG_W-1:0]         wr_tag;
	logic                         wr_valid;
	logic                         wr_dirty;

	// read back at the lookup index
	logic                         hit;
	logic                         valid;
	logic                         dirty;
	logic [`DC_TAG_W-1:0]         tag;
	line_t                        line;

	modport ctrl (
		output lk_index, lk_tag, lk_offset,
		output wr_en, wr_index, wr_line, wr_tag, wr_valid, wr_dirty
	);

	modport way (
		input  lk_index, lk_tag,
		input  wr_en, wr_index, wr_line, wr_tag, wr_valid, wr_dirty,
		output hit, valid, dirty, tag, line
	);

	modport sel (
		input lk_index, lk_offset,
		input hit, valid, dirty, tag, line
	);

endinterface

`default_nettype wire

/* rtl/dcache_pkg.sv */
`default_nettype none
`include "dcache_settings.svh"

package dcache_pkg;

	// field view of a request address, msb first
	typedef struct packed {
		logic [`DC_TAG_W-1:0]    tag;
		logic [`DC_INDEX_W-1:0]  index;
		logic [`DC_OFFSET_W-1:0] word_off;
		logic [1:0]              byte_off;
	} addr_fields_t;

	// raw view goes to memory, field view indexes the ways
	typedef union packed {
		logic [31:0]  raw;
		addr_fields_t f;
	} addr_u;

	typedef logic [31:0] word_t;

	// word 0 sits at the lowest address of the line
	typedef word_t [`DC_WORDS_PER_LINE-1:0] line_t;

	typedef logic way_idx_t;

endpackage

`default_nettype wire

/* include/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// cache geometry
// two ways only, the LRU state is a single bit per set
`define DC_WAYS 2
`define DC_SETS 16
`define DC_WORDS_PER_LINE 4

// write-back credits held after reset
`define DC_WB_CREDITS 2

// derived address widths for a 32-bit byte address
`define DC_INDEX_W $clog2(`DC_SETS)
`define DC_OFFSET_W $clog2(`DC_WORDS_PER_LINE)
`define DC_TAG_W (32 - `DC_INDEX_W - `DC_OFFSET_W - 2)

`endif
